//--- verilog/video_pkg.sv
// ====================
// video timing and pixel types
// ====================

package video_pkg;

  localparam int color_w = 8;   // bits per colour channel
  localparam int dim_w   = 16;  // resolution counter width

  // one pixel, r in the top byte
  typedef struct packed {
    logic [color_w-1:0] r;
    logic [color_w-1:0] g;
    logic [color_w-1:0] b;
  } rgb_t;

  // dvi receiver side, also used inside the overlay path
  typedef struct packed {
    logic hs;  // hsync as received
    logic vs;  // vsync, rising edge starts a frame
    logic de;  // active video
    rgb_t rgb;
  } video_bus_t;

  // what the vga dac gets
  typedef struct packed {
    logic hs;
    logic vs;
    logic blank_n;  // low forces the dac to black
    rgb_t rgb;
  } vga_bus_t;

  // width or height in pixels / lines
  typedef logic [dim_w-1:0] dim_t;

endpackage

//--- verilog/overlay_pkg.sv
// ====================
// overlay stream types
// ====================

package overlay_pkg;

  // pixel fifo sizing, depth is a power of two
  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = 4;  // log2(fifo_depth)

  // one overlay pixel as it sits in the fifo
  typedef struct packed {
    logic [6:0]      spare;   // bits 31:25, unused
    logic            opaque;  // bit 24, replace video when set
    video_pkg::rgb_t rgb;     // bits 23:0
  } ovl_pixel_t;

  // dma beat carries two pixels
  typedef struct packed {
    ovl_pixel_t hi;  // second pixel
    ovl_pixel_t lo;  // first pixel on screen
  } dma_word_t;

  // where overlay pixels come from
  typedef enum logic {
    src_dma,
    src_pattern
  } src_mode_e;

endpackage

//--- verilog/pixel_word_unpacker.sv
`timescale 1ns/1ps

// splits 64-bit dma beats into two fifo pushes, or generates a ramp pattern
module pixel_word_unpacker (
  input  logic                    odck_to_overlay,
  input  logic                    hps_fpga_reset_n,
  input  overlay_pkg::dma_word_t  dma_data_i,
  input  logic                    dma_valid_i,
  output logic                    dma_ready_o,
  input  overlay_pkg::src_mode_e  mode_i,
  input  logic                    full_i,
  output logic                    push_o,
  output overlay_pkg::ovl_pixel_t push_data_o
);

  typedef enum logic [1:0] {
    st_idle,  // nothing held, can take a beat
    st_low,   // whole beat held, low half next
    st_high   // only high half left
  } hold_e;

  hold_e                         state_q;
  overlay_pkg::dma_word_t        word_q;     // captured beat
  logic [video_pkg::color_w-1:0] pat_cnt_q;  // ramp value
  logic                          dma_fire;
  logic                          pat_push;
  overlay_pkg::ovl_pixel_t       pat_pixel;

  // ====================
  // handshake and push decode
  // ====================

  // ready only with empty holding reg, never in pattern mode
  assign dma_ready_o = (state_q == st_idle) && (mode_i == overlay_pkg::src_dma);
  assign dma_fire    = dma_valid_i && dma_ready_o;

  // held dma pixels drain first, pattern only fills gaps
  assign pat_push = (state_q == st_idle) && (mode_i == overlay_pkg::src_pattern) && !full_i;
  assign push_o   = ((state_q != st_idle) && !full_i) || pat_push;

  always_comb
  begin
    pat_pixel        = '0;
    pat_pixel.opaque = 1'b1;       // ramp always covers video
    pat_pixel.rgb.r  = pat_cnt_q;  // grey ramp
    pat_pixel.rgb.g  = pat_cnt_q;
    pat_pixel.rgb.b  = pat_cnt_q;
  end

  always_comb
  begin
    case (state_q)
      st_low:  push_data_o = word_q.lo;
      st_high: push_data_o = word_q.hi;
      default: push_data_o = pat_pixel;
    endcase
  end

  // ====================
  // state
  // ====================

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      state_q   <= st_idle;
      pat_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        st_idle: if (dma_fire) state_q <= st_low;
        st_low:  if (!full_i) state_q <= st_high;  // low half pushed
        st_high: if (!full_i) state_q <= st_idle;  // high half pushed
        default: state_q <= st_idle;
      endcase
      if (pat_push)
        pat_cnt_q <= pat_cnt_q + 1'b1;  // wraps at 255
    end
  end

  // captured beat payload
  always_ff @(posedge odck_to_overlay)
  begin
    if (dma_fire)
      word_q <= dma_data_i;
  end

  // source keeps data steady until the beat is taken
  a_dma_hold: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    dma_valid_i && !dma_ready_o |=> !dma_valid_i || $stable(dma_data_i)
  ) else $error("dma_data_i changed while transfer pending");

endmodule

//--- verilog/pixel_fifo.sv
`timescale 1ns/1ps

// show-ahead circular buffer, head is valid whenever not empty
module pixel_fifo (
  input  logic                    odck_to_overlay,
  input  logic                    hps_fpga_reset_n,
  input  logic                    push_i,
  input  overlay_pkg::ovl_pixel_t push_data_i,
  input  logic                    pop_i,
  output overlay_pkg::ovl_pixel_t head_o,
  output logic                    full_o,
  output logic                    empty_o
);

  overlay_pkg::ovl_pixel_t         mem [overlay_pkg::fifo_depth];
  logic [overlay_pkg::fifo_ptr_w-1:0] wr_ptr_q;
  logic [overlay_pkg::fifo_ptr_w-1:0] rd_ptr_q;
  logic [overlay_pkg::fifo_ptr_w:0]   count_q;  // one extra bit for full
  logic                               do_push;
  logic                               do_pop;

  // ====================
  // flags and head
  // ====================

  // depth is 2^ptr_w so msb of count means full
  assign full_o  = count_q[overlay_pkg::fifo_ptr_w];
  assign empty_o = (count_q == '0);
  assign head_o  = mem[rd_ptr_q];  // oldest word, no read latency

  // guarded internally too
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // word storage
  always_ff @(posedge odck_to_overlay)
  begin
    if (do_push)
      mem[wr_ptr_q] <= push_data_i;
  end

  // ====================
  // pointers
  // ====================

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps with ptr width
      if (do_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;  // both or neither, count unchanged
      endcase
    end
  end

  // producer and consumer must respect the flags
  a_no_push_full: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    !(push_i && full_o)
  ) else $error("push while fifo full");

  a_no_pop_empty: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    !(pop_i && empty_o)
  ) else $error("pop while fifo empty");

endmodule

//--- verilog/overlay_mixer.sv
`timescale 1ns/1ps

// keys fifo pixels onto live video, one registered stage to the vga pins
module overlay_mixer (
  input  logic                    odck_to_overlay,
  input  logic                    hps_fpga_reset_n,
  input  video_pkg::video_bus_t   video_i,
  input  logic                    overlay_en_i,
  input  logic                    blank_i,
  input  overlay_pkg::ovl_pixel_t head_i,
  input  logic                    empty_i,
  output logic                    pop_o,
  output video_pkg::vga_bus_t     vga_o,
  output logic                    ovf_o
);

  logic                want_pop;  // this pixel should take an overlay word
  logic                use_ovl;   // popped word covers the video
  video_pkg::rgb_t     mix_rgb;
  video_pkg::vga_bus_t vga_d;

  // ====================
  // fifo side
  // ====================

  // one word per active pixel while overlay is on
  assign want_pop = video_i.de && overlay_en_i;
  assign pop_o    = want_pop && !empty_i;  // underflow just skips the pop

  // transparent words still get consumed
  assign use_ovl = pop_o && head_i.opaque;
  assign mix_rgb = use_ovl ? head_i.rgb : video_i.rgb;

  // ====================
  // vga side
  // ====================

  always_comb
  begin
    vga_d         = '0;
    vga_d.hs      = video_i.hs;  // sync untouched
    vga_d.vs      = video_i.vs;
    vga_d.blank_n = video_i.de && !blank_i;  // blank switch forces black
    vga_d.rgb     = mix_rgb;
  end

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      vga_o <= '0;
      ovf_o <= 1'b0;
    end
    else
    begin
      vga_o <= vga_d;  // fixed 1 cycle latency, video never waits
      if (want_pop && empty_i)
        ovf_o <= 1'b1;  // sticky until reset
    end
  end

  // a popped word was written by the producer
  a_pop_known: assert property (
    @(posedge odck_to_overlay) disable iff (!hps_fpga_reset_n)
    pop_o |-> !$isunknown(head_i)
  ) else $error("mixer popped unwritten fifo word");

endmodule

//--- verilog/resolution_meter.sv
`timescale 1ns/1ps

// measures active width and height of incoming frames
module resolution_meter (
  input  logic                  odck_to_overlay,
  input  logic                  hps_fpga_reset_n,
  input  video_pkg::video_bus_t video_i,
  output video_pkg::dim_t       width_o,
  output video_pkg::dim_t       height_o
);

  logic            de_q;        // de from last cycle
  logic            vs_q;        // vs from last cycle
  video_pkg::dim_t pix_cnt_q;   // pixels in current line
  video_pkg::dim_t line_cnt_q;  // lines in current frame
  video_pkg::dim_t last_w_q;    // width of last finished line
  logic            de_fall;
  logic            vs_rise;
  video_pkg::dim_t lines_now;   // includes a line ending this cycle
  video_pkg::dim_t width_now;

  assign de_fall = de_q && !video_i.de;
  assign vs_rise = video_i.vs && !vs_q;

  // a line closing on the vs edge still counts
  assign lines_now = de_fall ? line_cnt_q + 1'b1 : line_cnt_q;
  assign width_now = de_fall ? pix_cnt_q : last_w_q;

  always_ff @(posedge odck_to_overlay or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      de_q       <= 1'b0;
      vs_q       <= 1'b0;
      pix_cnt_q  <= '0;
      line_cnt_q <= '0;
      last_w_q   <= '0;
      width_o    <= '0;
      height_o   <= '0;
    end
    else
    begin
      de_q <= video_i.de;
      vs_q <= video_i.vs;

      // ====================
      // line and frame counters
      // ====================
      if (video_i.de)
        pix_cnt_q <= pix_cnt_q + 1'b1;
      else if (de_fall)
        pix_cnt_q <= '0;  // restart after storing

      last_w_q <= width_now;

      if (vs_rise)
      begin
        width_o    <= width_now;  // last line of previous frame
        height_o   <= lines_now;
        line_cnt_q <= '0;
      end
      else
        line_cnt_q <= lines_now;
    end
  end

endmodule

//--- verilog/danmaku_overlay_top.sv
`timescale 1ns/1ps

// overlay path: dma/pattern producer -> fifo -> mixer, plus resolution meter
module danmaku_overlay_top (
  input  logic                   odck_to_overlay,
  input  logic                   hps_fpga_reset_n,
  input  overlay_pkg::dma_word_t dma_data_i,
  input  logic                   dma_valid_i,
  output logic                   dma_ready_o,
  input  video_pkg::video_bus_t  video_i,
  input  logic                   overlay_en_i,
  input  logic                   blank_i,
  input  logic                   pattern_i,
  output video_pkg::vga_bus_t    vga_o,
  output logic                   ovf_o,
  output video_pkg::dim_t        width_o,
  output video_pkg::dim_t        height_o
);

  logic                    push;
  overlay_pkg::ovl_pixel_t push_data;
  logic                    full;
  overlay_pkg::ovl_pixel_t head;
  logic                    empty;
  logic                    pop;

  // ====================
  // overlay pixel source
  // ====================

  pixel_word_unpacker pixel_word_unpacker_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .dma_data_i       (dma_data_i),
    .dma_valid_i      (dma_valid_i),
    .dma_ready_o      (dma_ready_o),
    .mode_i           (pattern_i ? overlay_pkg::src_pattern : overlay_pkg::src_dma),
    .full_i           (full),
    .push_o           (push),
    .push_data_o      (push_data)
  );

  pixel_fifo pixel_fifo_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .push_i           (push),
    .push_data_i      (push_data),
    .pop_i            (pop),
    .head_o           (head),
    .full_o           (full),
    .empty_o          (empty)
  );

  // ====================
  // video path
  // ====================

  overlay_mixer overlay_mixer_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .video_i          (video_i),
    .overlay_en_i     (overlay_en_i),
    .blank_i          (blank_i),
    .head_i           (head),
    .empty_i          (empty),
    .pop_o            (pop),
    .vga_o            (vga_o),
    .ovf_o            (ovf_o)
  );

  resolution_meter resolution_meter_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .video_i          (video_i),  // same dvi stream as the mixer
    .width_o          (width_o),
    .height_o         (height_o)
  );

endmodule

//--- verif/tb_danmaku_overlay.sv
`timescale 1ns/1ps

module tb_danmaku_overlay;

  localparam int accept_limit = 64;  // cycles allowed for dma_ready_o

  logic                   odck_to_overlay;
  logic                   hps_fpga_reset_n;
  overlay_pkg::dma_word_t dma_data_i;
  logic                   dma_valid_i;
  logic                   dma_ready_o;
  video_pkg::video_bus_t  video_i;
  logic                   overlay_en_i;
  logic                   blank_i;
  logic                   pattern_i;
  video_pkg::vga_bus_t    vga_o;
  logic                   ovf_o;
  video_pkg::dim_t        width_o;
  video_pkg::dim_t        height_o;

  integer                  seed;
  overlay_pkg::ovl_pixel_t ovl_q[$];  // what the fifo should hold, oldest first
  logic                    model_ovf;  // expected sticky underflow
  video_pkg::vga_bus_t     pend_exp;   // expected vga_o for last driven pixel
  logic                    pend_ovf;
  logic                    pend_valid;

  danmaku_overlay_top danmaku_overlay_top_inst (
    .odck_to_overlay  (odck_to_overlay),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .dma_data_i       (dma_data_i),
    .dma_valid_i      (dma_valid_i),
    .dma_ready_o      (dma_ready_o),
    .video_i          (video_i),
    .overlay_en_i     (overlay_en_i),
    .blank_i          (blank_i),
    .pattern_i        (pattern_i),
    .vga_o            (vga_o),
    .ovf_o            (ovf_o),
    .width_o          (width_o),
    .height_o         (height_o)
  );

  always #20 odck_to_overlay = ~odck_to_overlay;  // 40 ns period

  // ====================
  // helpers
  // ====================

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    assert (got === exp)
    else
    begin
      $display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic video_pkg::video_bus_t random_video(input logic hs, input logic vs,
                                                         input logic de);
    video_pkg::video_bus_t v;
    logic [31:0]           r;
    r     = $random(seed);
    v     = '0;
    v.hs  = hs;
    v.vs  = vs;
    v.de  = de;
    v.rgb = r[23:0];  // random colour under the overlay
    return v;
  endfunction

  function automatic overlay_pkg::ovl_pixel_t make_pixel(input logic opaque,
                                                         input logic [23:0] rgb);
    overlay_pkg::ovl_pixel_t p;
    p        = '0;
    p.opaque = opaque;
    p.rgb    = rgb;
    return p;
  endfunction

  // opaque pixel with a colour unique to its index
  function automatic overlay_pkg::ovl_pixel_t seq_pixel(input int i);
    logic [7:0] b;
    b = i[7:0];
    return make_pixel(1'b1, {b, b ^ 8'h5a, ~b});
  endfunction

  function automatic overlay_pkg::dma_word_t make_word(input overlay_pkg::ovl_pixel_t lo,
                                                       input overlay_pkg::ovl_pixel_t hi);
    overlay_pkg::dma_word_t w;
    w.lo = lo;
    w.hi = hi;
    return w;
  endfunction

  task automatic reset_dut();
    @(posedge odck_to_overlay);
    hps_fpga_reset_n <= 1'b0;
    dma_valid_i      <= 1'b0;
    dma_data_i       <= '0;
    video_i          <= '0;
    overlay_en_i     <= 1'b0;
    blank_i          <= 1'b0;
    pattern_i        <= 1'b0;
    repeat (3) @(posedge odck_to_overlay);
    hps_fpga_reset_n <= 1'b1;
    @(negedge odck_to_overlay);
    ovl_q.delete();
    model_ovf  = 1'b0;
    pend_valid = 1'b0;
    expect_equal("dma_ready_o", dma_ready_o, 1'b1);  // idle, dma mode
    expect_equal("vga_o", vga_o, '0);
    expect_equal("ovf_o", ovf_o, 1'b0);
    expect_equal("width_o", width_o, '0);
    expect_equal("height_o", height_o, '0);
  endtask

  // overlay rule per pixel: pop on de with overlay on, opaque wins
  task automatic model_pixel(input video_pkg::video_bus_t v, input logic blank,
                             input logic ovl_on, output video_pkg::vga_bus_t exp);
    overlay_pkg::ovl_pixel_t p;
    exp         = '0;
    exp.hs      = v.hs;
    exp.vs      = v.vs;
    exp.blank_n = v.de && !blank;
    exp.rgb     = v.rgb;
    if (v.de && ovl_on)
    begin
      if (ovl_q.size() == 0)
        model_ovf = 1'b1;  // underflow, video shows through
      else
      begin
        p = ovl_q.pop_front();
        if (p.opaque)
          exp.rgb = p.rgb;
      end
    end
  endtask

  // one pixel in, previous pixel's result checked
  task automatic video_step(input video_pkg::video_bus_t v, input logic blank,
                            input logic ovl_on);
    video_pkg::vga_bus_t exp;
    @(posedge odck_to_overlay);
    video_i      <= v;
    blank_i      <= blank;
    overlay_en_i <= ovl_on;
    @(negedge odck_to_overlay);
    if (pend_valid)
    begin
      expect_equal("vga_o", vga_o, pend_exp);
      expect_equal("ovf_o", ovf_o, pend_ovf);
    end
    model_pixel(v, blank, ovl_on, exp);
    pend_exp   = exp;
    pend_ovf   = model_ovf;
    pend_valid = 1'b1;
  endtask

  task automatic video_flush();
    video_step(random_video(1'b0, 1'b0, 1'b0), 1'b0, 1'b0);
    pend_valid = 1'b0;  // trailing idle pixel left unchecked
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) video_step(random_video(1'b0, 1'b0, 1'b0), 1'b0, 1'b0);
  endtask

  task automatic offer_dma_word(input overlay_pkg::dma_word_t w);
    @(posedge odck_to_overlay);
    dma_data_i  <= w;
    dma_valid_i <= 1'b1;
    ovl_q.push_back(w.lo);  // low half shows first
    ovl_q.push_back(w.hi);
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge odck_to_overlay);
    while (!dma_ready_o && n < accept_limit)
    begin
      @(negedge odck_to_overlay);
      n = n + 1;
    end
    assert (dma_ready_o)
    else
    begin
      $display("dma_ready_o stayed low, the offered word was never accepted");
      $display("RESULT: FAIL");
      $fatal(1, "handshake timeout");
    end
    @(posedge odck_to_overlay);  // transfer on this edge
    dma_valid_i <= 1'b0;
  endtask

  task automatic send_dma_word(input overlay_pkg::dma_word_t w);
    offer_dma_word(w);
    wait_accept();
  endtask

  // ====================
  // directed tests
  // ====================

  task automatic test_passthrough();
    logic [31:0] r;
    reset_dut();
    repeat (40)
    begin
      r = $random(seed);
      video_step(random_video(r[31], r[30], r[29]), 1'b0, 1'b0);
    end
    video_flush();
  endtask

  task automatic test_dma_keying();
    reset_dut();
    send_dma_word(make_word(make_pixel(1'b1, 24'h123456), make_pixel(1'b0, 24'h00ff00)));
    send_dma_word(make_word(make_pixel(1'b0, 24'habcdef), make_pixel(1'b1, 24'hff0000)));
    send_dma_word(make_word(make_pixel(1'b1, 24'h0000ff), make_pixel(1'b0, 24'h777777)));
    idle_cycles(3);  // last pushes land
    repeat (6) video_step(random_video(1'b0, 1'b0, 1'b1), 1'b0, 1'b1);
    video_flush();
  endtask

  task automatic test_backpressure();
    int i;
    reset_dut();
    for (i = 0; i < 9; i++)
      send_dma_word(make_word(seq_pixel(2 * i), seq_pixel(2 * i + 1)));
    offer_dma_word(make_word(seq_pixel(18), seq_pixel(19)));
    repeat (6)
    begin
      @(negedge odck_to_overlay);
      expect_equal("dma_ready_o", dma_ready_o, 1'b0);  // fifo full, word 8 held
    end
    fork
      wait_accept();  // last word goes in once pops free space
      repeat (20) video_step(random_video(1'b0, 1'b0, 1'b1), 1'b0, 1'b1);
    join
    video_flush();
  endtask

  task automatic test_pattern();
    int         i;
    logic [7:0] b;
    reset_dut();
    @(posedge odck_to_overlay);
    pattern_i <= 1'b1;
    for (i = 0; i < 24; i++)
    begin
      b = i[7:0];
      ovl_q.push_back(make_pixel(1'b1, {b, b, b}));  // grey ramp from reset
    end
    idle_cycles(20);  // fifo fills with the ramp
    expect_equal("dma_ready_o", dma_ready_o, 1'b0);
    repeat (24) video_step(random_video(1'b0, 1'b0, 1'b1), 1'b0, 1'b1);
    video_flush();
  endtask

  task automatic test_blank_underflow();
    reset_dut();
    video_step(random_video(1'b0, 1'b0, 1'b1), 1'b0, 1'b1);  // fifo empty
    expect_equal("ovf_o", ovf_o, 1'b0);
    repeat (4) video_step(random_video(1'b0, 1'b0, 1'b1), 1'b0, 1'b1);
    idle_cycles(2);
    repeat (4) video_step(random_video(1'b0, 1'b0, 1'b1), 1'b1, 1'b0);  // blanked de
    video_flush();
  endtask

  task automatic run_frame();
    repeat (20)
    begin
      repeat (12) video_step(random_video(1'b0, 1'b0, 1'b1), 1'b0, 1'b0);
      repeat (4) video_step(random_video(1'b1, 1'b0, 1'b0), 1'b0, 1'b0);  // hblank
    end
  endtask

  task automatic vsync_pulse();
    repeat (3) video_step(random_video(1'b0, 1'b1, 1'b0), 1'b0, 1'b0);
    idle_cycles(2);
  endtask

  task automatic test_resolution();
    reset_dut();
    idle_cycles(2);
    run_frame();
    vsync_pulse();
    run_frame();
    vsync_pulse();  // second rise latches the frame
    video_flush();
    expect_equal("width_o", width_o, 16'd12);
    expect_equal("height_o", height_o, 16'd20);
  endtask

  initial
  begin
    seed             = 64523;
    odck_to_overlay  = 1'b0;
    hps_fpga_reset_n = 1'b0;
    dma_data_i       = '0;
    dma_valid_i      = 1'b0;
    video_i          = '0;
    overlay_en_i     = 1'b0;
    blank_i          = 1'b0;
    pattern_i        = 1'b0;
    model_ovf        = 1'b0;
    pend_exp         = '0;
    pend_ovf         = 1'b0;
    pend_valid       = 1'b0;
    test_passthrough();
    test_dma_keying();
    test_backpressure();
    test_pattern();
    test_blank_underflow();
    test_resolution();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- flist.f
verilog/video_pkg.sv
verilog/overlay_pkg.sv
verilog/pixel_word_unpacker.sv
verilog/pixel_fifo.sv
verilog/overlay_mixer.sv
verilog/resolution_meter.sv
verilog/danmaku_overlay_top.sv
verif/tb_danmaku_overlay.sv

//--- Bender.yml
package:
  name: danmaku_overlay

sources:
  - verilog/video_pkg.sv
  - verilog/overlay_pkg.sv
  - verilog/pixel_word_unpacker.sv
  - verilog/pixel_fifo.sv
  - verilog/overlay_mixer.sv
  - verilog/resolution_meter.sv
  - verilog/danmaku_overlay_top.sv
  - target: test
    files:
      - verif/tb_danmaku_overlay.sv
